//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_REG_COUNT   8
`define CPU_DATA_W      32
`define CPU_ADDR_W      32
`define CPU_REG_NUM_W   3
`define CPU_IMM_W       16
`define CPU_OPC_W       4
`define CPU_INSTR_W     32
`define CPU_INSTR_BYTES 4

// Instruction word layout, imm sits in the low bits
`define CPU_OPC_LSB     28
`define CPU_RD_LSB      25
`define CPU_RS_LSB      22

`define CPU_OP_NOP      4'h0
`define CPU_OP_MOVI     4'h1
`define CPU_OP_ADD      4'h2
`define CPU_OP_SUB      4'h3
`define CPU_OP_AND      4'h4
`define CPU_OP_OR       4'h5
`define CPU_OP_XOR      4'h6
`define CPU_OP_STORE    4'h7

`endif

//--- cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

   typedef enum logic [`CPU_OPC_W-1:0] {
      OP_NOP   = `CPU_OP_NOP,
      OP_MOVI  = `CPU_OP_MOVI,
      OP_ADD   = `CPU_OP_ADD,
      OP_SUB   = `CPU_OP_SUB,
      OP_AND   = `CPU_OP_AND,
      OP_OR    = `CPU_OP_OR,
      OP_XOR   = `CPU_OP_XOR,
      OP_STORE = `CPU_OP_STORE
   } opcode_e;

   // Decode to register access
   typedef struct packed {
      opcode_e                   opcode;
      logic [`CPU_REG_NUM_W-1:0] rd;
      logic [`CPU_REG_NUM_W-1:0] rs;
      logic [`CPU_IMM_W-1:0]     imm;
   } decoded_instr_t;

   // Register access to execute, operands already read
   typedef struct packed {
      opcode_e                   opcode;
      logic [`CPU_REG_NUM_W-1:0] rd;
      logic [`CPU_DATA_W-1:0]    rd_value;
      logic [`CPU_DATA_W-1:0]    rs_value;
      logic [`CPU_IMM_W-1:0]     imm;
   } exec_op_t;

endpackage

`default_nettype wire

//--- pipe_skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_skid_buffer #(
   parameter type payload_t = logic [31:0]
) (
   input  wire           clk,
   input  wire           reset,

   input  wire           in_valid,
   output logic          in_ready,
   input  wire payload_t in_data,

   output logic          out_valid,
   input  wire           out_ready,
   output payload_t      out_data
);

   logic     spare_valid;
   payload_t spare_data;
   logic     in_fire;
   logic     main_free;

   // Ready comes straight from a flop
   assign in_ready  = ~spare_valid;
   assign in_fire   = in_valid & in_ready;
   assign main_free = ~out_valid | out_ready;   // Main empty or leaving now

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid   <= 1'b0;
         spare_valid <= 1'b0;
      end else if (main_free) begin
         out_valid   <= spare_valid | in_fire;
         spare_valid <= 1'b0;
      end else if (in_fire) begin
         spare_valid <= 1'b1;   // Output stalled, park the item
      end
   end

   always_ff @(posedge clk) begin
      if (main_free) begin
         if (spare_valid) begin
            out_data <= spare_data;   // Older item goes first
         end else if (in_fire) begin
            out_data <= in_data;
         end
      end else if (in_fire) begin
         spare_data <= in_data;
      end
   end

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module fetch_unit (
   input  wire                     clk,
   input  wire                     reset,

   output logic                    imem_valid,
   input  wire                     imem_ready,
   output logic [`CPU_ADDR_W-1:0]  imem_address,

   input  wire                     imem_dp_valid,
   output logic                    imem_dp_ready,
   input  wire [`CPU_INSTR_W-1:0]  imem_dp_read_data,

   output logic                    f_valid,
   input  wire                     f_ready,
   output logic [`CPU_INSTR_W-1:0] f_instruction
);

   logic                   run_q;    // Low for one cycle after reset
   logic                   pend_q;   // Request accepted, word not yet passed on
   logic [`CPU_ADDR_W-1:0] pc_q;

   assign imem_valid   = run_q & ~pend_q;
   assign imem_address = pc_q;

   // Response goes to decode with its own handshake
   assign f_valid       = pend_q & imem_dp_valid;
   assign imem_dp_ready = pend_q & f_ready;
   assign f_instruction = imem_dp_read_data;

   always_ff @(posedge clk) begin
      if (reset) begin
         run_q  <= 1'b0;
         pend_q <= 1'b0;
         pc_q   <= '0;
      end else begin
         run_q <= 1'b1;
         if (imem_valid && imem_ready) begin
            pend_q <= 1'b1;
            pc_q   <= pc_q + `CPU_ADDR_W'(`CPU_INSTR_BYTES);
         end else if (f_valid && f_ready) begin
            pend_q <= 1'b0;   // Next request goes out next cycle
         end
      end
   end

endmodule

`default_nettype wire

//--- decode_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module decode_unit import cpu_pkg::*; (
   input  wire                    clk,
   input  wire                    reset,

   input  wire                    f_valid,
   output logic                   f_ready,
   input  wire [`CPU_INSTR_W-1:0] f_instruction,

   output logic                   d_valid,
   input  wire                    d_ready,
   output decoded_instr_t         d_instr
);

   logic [`CPU_OPC_W-1:0] opc_field;
   decoded_instr_t        fields;

   assign opc_field = f_instruction[`CPU_OPC_LSB +: `CPU_OPC_W];

   always_comb begin
      fields.rd  = f_instruction[`CPU_RD_LSB +: `CPU_REG_NUM_W];
      fields.rs  = f_instruction[`CPU_RS_LSB +: `CPU_REG_NUM_W];
      fields.imm = f_instruction[`CPU_IMM_W-1:0];
      case (opc_field)
         `CPU_OP_MOVI,
         `CPU_OP_ADD,
         `CPU_OP_SUB,
         `CPU_OP_AND,
         `CPU_OP_OR,
         `CPU_OP_XOR,
         `CPU_OP_STORE: fields.opcode = opcode_e'(opc_field);
         default:       fields.opcode = OP_NOP;   // Also catches unused codes
      endcase
   end

   pipe_skid_buffer #(
      .payload_t (decoded_instr_t)
   ) uut_decode_buf (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (f_valid),
      .in_ready  (f_ready),
      .in_data   (fields),
      .out_valid (d_valid),
      .out_ready (d_ready),
      .out_data  (d_instr)
   );

endmodule

`default_nettype wire

//--- register_access.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module register_access import cpu_pkg::*; (
   input  wire                      clk,
   input  wire                      reset,

   input  wire                      d_valid,
   output logic                     d_ready,
   input  wire decoded_instr_t      d_instr,

   output logic                     r_valid,
   input  wire                      r_ready,
   output exec_op_t                 r_op,

   input  wire                      wb_en,
   input  wire [`CPU_REG_NUM_W-1:0] wb_reg,
   input  wire [`CPU_DATA_W-1:0]    wb_data
);

   logic [`CPU_DATA_W-1:0]    regs [`CPU_REG_COUNT];
   logic [`CPU_REG_COUNT-1:0] pend_q;
   logic [`CPU_REG_COUNT-1:0] wb_mask;
   logic [`CPU_REG_COUNT-1:0] set_mask;
   logic [`CPU_REG_COUNT-1:0] pend_now;
   logic                      writes_rd;
   logic                      reads_rs;
   logic                      hazard;
   logic                      buf_ready;
   logic                      fwd;
   exec_op_t                  op;

   assign wb_mask  = wb_en ? (`CPU_REG_COUNT'(1) << wb_reg) : '0;
   assign pend_now = pend_q & ~wb_mask;   // Writeback this cycle clears its bit

   always_comb begin
      writes_rd = 1'b0;
      reads_rs  = 1'b0;
      case (d_instr.opcode)
         OP_MOVI: writes_rd = 1'b1;
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
            writes_rd = 1'b1;
            reads_rs  = 1'b1;
         end
         default: ;
      endcase
   end

   // Every opcode but NOP touches rd
   assign hazard = ((d_instr.opcode != OP_NOP) && pend_now[d_instr.rd]) ||
                   (reads_rs && pend_now[d_instr.rs]);

   assign d_ready  = buf_ready & ~hazard;
   assign fwd      = d_valid & d_ready;
   assign set_mask = (fwd && writes_rd) ? (`CPU_REG_COUNT'(1) << d_instr.rd) : '0;

   // Operand read with writeback bypass
   always_comb begin
      op.opcode   = d_instr.opcode;
      op.rd       = d_instr.rd;
      op.imm      = d_instr.imm;
      op.rd_value = (wb_en && wb_reg == d_instr.rd) ? wb_data : regs[d_instr.rd];
      op.rs_value = (wb_en && wb_reg == d_instr.rs) ? wb_data : regs[d_instr.rs];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pend_q <= '0;
         for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else begin
         pend_q <= pend_now | set_mask;
         if (wb_en) begin
            regs[wb_reg] <= wb_data;
         end
      end
   end

   pipe_skid_buffer #(
      .payload_t (exec_op_t)
   ) uut_reg_buf (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (d_valid & ~hazard),
      .in_ready  (buf_ready),
      .in_data   (op),
      .out_valid (r_valid),
      .out_ready (r_ready),
      .out_data  (r_op)
   );

endmodule

`default_nettype wire

//--- execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module execute_unit import cpu_pkg::*; (
   input  wire                       clk,
   input  wire                       reset,

   input  wire                       r_valid,
   output logic                      r_ready,
   input  wire exec_op_t             r_op,

   output logic                      wb_en,
   output logic [`CPU_REG_NUM_W-1:0] wb_reg,
   output logic [`CPU_DATA_W-1:0]    wb_data,

   output logic                      wmem_valid,
   input  wire                       wmem_ready,
   output logic [`CPU_ADDR_W-1:0]    wmem_address,
   output logic [`CPU_DATA_W-1:0]    wmem_wr_data
);

   logic                      out_valid_q;
   logic                      out_store_q;   // Held item goes to wmem
   logic [`CPU_REG_NUM_W-1:0] out_reg_q;
   logic [`CPU_DATA_W-1:0]    out_data_q;
   logic [`CPU_ADDR_W-1:0]    out_addr_q;
   logic [`CPU_DATA_W-1:0]    result;
   logic                      drain;
   logic                      accept;

   // Writeback always drains, a store waits on wmem_ready
   assign drain   = out_valid_q & (~out_store_q | wmem_ready);
   assign r_ready = ~out_valid_q | drain;
   assign accept  = r_valid & r_ready;

   assign wb_en        = out_valid_q & ~out_store_q;
   assign wb_reg       = out_reg_q;
   assign wb_data      = out_data_q;
   assign wmem_valid   = out_valid_q & out_store_q;
   assign wmem_address = out_addr_q;
   assign wmem_wr_data = out_data_q;

   always_comb begin
      case (r_op.opcode)
         OP_MOVI: result = `CPU_DATA_W'(r_op.imm);
         OP_ADD:  result = r_op.rd_value + r_op.rs_value;
         OP_SUB:  result = r_op.rd_value - r_op.rs_value;
         OP_AND:  result = r_op.rd_value & r_op.rs_value;
         OP_OR:   result = r_op.rd_value | r_op.rs_value;
         OP_XOR:  result = r_op.rd_value ^ r_op.rs_value;
         default: result = r_op.rd_value;   // Store data
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid_q <= 1'b0;
         out_store_q <= 1'b0;
      end else if (accept) begin
         out_valid_q <= (r_op.opcode != OP_NOP);   // NOP retires here
         out_store_q <= (r_op.opcode == OP_STORE);
      end else if (drain) begin
         out_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         out_reg_q  <= r_op.rd;
         out_data_q <= result;
         out_addr_q <= `CPU_ADDR_W'(r_op.imm);   // Word address
      end
   end

endmodule

`default_nettype wire

//--- top_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module top_pipeline import cpu_pkg::*; (
   input  wire                    clk,
   input  wire                    reset,

   output logic                   imem_valid,
   input  wire                    imem_ready,
   output logic [`CPU_ADDR_W-1:0] imem_address,
   input  wire                    imem_dp_valid,
   output logic                   imem_dp_ready,
   input  wire [`CPU_INSTR_W-1:0] imem_dp_read_data,

   output logic                   wmem_valid,
   input  wire                    wmem_ready,
   output logic [`CPU_ADDR_W-1:0] wmem_address,
   output logic [`CPU_DATA_W-1:0] wmem_wr_data
);

   // Fetch to decode
   logic                      f_valid;
   logic                      f_ready;
   logic [`CPU_INSTR_W-1:0]   f_instruction;

   // Decode to register access
   logic                      d_valid;
   logic                      d_ready;
   decoded_instr_t            d_instr;

   // Register access to execute
   logic                      r_valid;
   logic                      r_ready;
   exec_op_t                  r_op;

   // Writeback
   logic                      wb_en;
   logic [`CPU_REG_NUM_W-1:0] wb_reg;
   logic [`CPU_DATA_W-1:0]    wb_data;

   fetch_unit uut_fetch (
      .clk               (clk),
      .reset             (reset),
      .imem_valid        (imem_valid),
      .imem_ready        (imem_ready),
      .imem_address      (imem_address),
      .imem_dp_valid     (imem_dp_valid),
      .imem_dp_ready     (imem_dp_ready),
      .imem_dp_read_data (imem_dp_read_data),
      .f_valid           (f_valid),
      .f_ready           (f_ready),
      .f_instruction     (f_instruction)
   );

   decode_unit uut_decode (
      .clk           (clk),
      .reset         (reset),
      .f_valid       (f_valid),
      .f_ready       (f_ready),
      .f_instruction (f_instruction),
      .d_valid       (d_valid),
      .d_ready       (d_ready),
      .d_instr       (d_instr)
   );

   register_access uut_register_access (
      .clk     (clk),
      .reset   (reset),
      .d_valid (d_valid),
      .d_ready (d_ready),
      .d_instr (d_instr),
      .r_valid (r_valid),
      .r_ready (r_ready),
      .r_op    (r_op),
      .wb_en   (wb_en),
      .wb_reg  (wb_reg),
      .wb_data (wb_data)
   );

   execute_unit uut_execute (
      .clk          (clk),
      .reset        (reset),
      .r_valid      (r_valid),
      .r_ready      (r_ready),
      .r_op         (r_op),
      .wb_en        (wb_en),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data),
      .wmem_valid   (wmem_valid),
      .wmem_ready   (wmem_ready),
      .wmem_address (wmem_address),
      .wmem_wr_data (wmem_wr_data)
   );

endmodule

`default_nettype wire

//--- top_pipeline_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module top_pipeline_checker (
   input wire                   clk,
   input wire                   reset,
   input wire                   imem_valid,
   input wire                   imem_ready,
   input wire [`CPU_ADDR_W-1:0] imem_address,
   input wire                   wmem_valid,
   input wire                   wmem_ready,
   input wire [`CPU_ADDR_W-1:0] wmem_address,
   input wire [`CPU_DATA_W-1:0] wmem_wr_data,
   input wire                   f_valid,
   input wire                   d_valid,
   input wire                   r_valid,
   input wire                   wb_en
);

   // Request held until taken
   a_imem_hold: assert property (@(posedge clk) disable iff (reset)
      imem_valid && !imem_ready |=> imem_valid && $stable(imem_address))
      else $error("imem request changed before imem_ready");

   a_wmem_hold: assert property (@(posedge clk) disable iff (reset)
      wmem_valid && !wmem_ready |=>
         wmem_valid && $stable(wmem_address) && $stable(wmem_wr_data))
      else $error("wmem store changed before wmem_ready");

   a_reset_quiet: assert property (@(posedge clk)
      reset && $past(reset) |->
         !imem_valid && !wmem_valid && !f_valid && !d_valid && !r_valid && !wb_en)
      else $error("valid signal high during reset");

endmodule

bind top_pipeline top_pipeline_checker i_checker (
   .clk          (clk),
   .reset        (reset),
   .imem_valid   (imem_valid),
   .imem_ready   (imem_ready),
   .imem_address (imem_address),
   .wmem_valid   (wmem_valid),
   .wmem_ready   (wmem_ready),
   .wmem_address (wmem_address),
   .wmem_wr_data (wmem_wr_data),
   .f_valid      (f_valid),
   .d_valid      (d_valid),
   .r_valid      (r_valid),
   .wb_en        (wb_en)
);

`default_nettype wire

//--- tb_top_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module tb_top_pipeline import cpu_pkg::*; ();

   localparam int PROG_MAX  = 64;
   localparam int RUN_LIMIT = 3000;   // Cycles per program

   logic                   clk;
   logic                   reset = 1'b1;
   logic                   imem_ready = 1'b0;
   logic                   imem_dp_valid = 1'b0;
   logic [`CPU_INSTR_W-1:0] imem_dp_read_data = '0;
   logic                   wmem_ready = 1'b0;
   wire                    imem_valid;
   wire [`CPU_ADDR_W-1:0]  imem_address;
   wire                    imem_dp_ready;
   wire                    wmem_valid;
   wire [`CPU_ADDR_W-1:0]  wmem_address;
   wire [`CPU_DATA_W-1:0]  wmem_wr_data;

   integer                 seed = 32'hc6f3d14a;
   bit                     random_mode = 1'b0;
   logic [31:0]            prog [PROG_MAX];
   int                     prog_len = 0;
   logic [31:0]            exp_addr [$];
   logic [31:0]            exp_data [$];
   int                     got_count = 0;
   int                     value_errors = 0;
   int                     other_errors = 0;
   logic                   rst_q = 1'b0;
   logic                   rst_qq = 1'b0;
   logic                   rsp_busy = 1'b0;
   int                     rsp_wait = 0;
   logic [31:0]            rsp_word = '0;
   logic [31:0]            next_fetch = '0;
   bit                     timed_out = 1'b0;

   top_pipeline i_dut (
      .clk               (clk),
      .reset             (reset),
      .imem_valid        (imem_valid),
      .imem_ready        (imem_ready),
      .imem_address      (imem_address),
      .imem_dp_valid     (imem_dp_valid),
      .imem_dp_ready     (imem_dp_ready),
      .imem_dp_read_data (imem_dp_read_data),
      .wmem_valid        (wmem_valid),
      .wmem_ready        (wmem_ready),
      .wmem_address      (wmem_address),
      .wmem_wr_data      (wmem_wr_data)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] encode(logic [3:0] op, int rd, int rs, int imm);
      return {op, rd[2:0], rs[2:0], 6'b0, imm[15:0]};
   endfunction

   function automatic logic [31:0] fetch_word(logic [31:0] addr);
      int idx;
      idx = int'(addr[31:2]);
      if (idx < prog_len) begin
         return prog[idx];
      end
      return '0;   // NOP past the end
   endfunction

   // Interprets the program and lists the stores it must produce
   function automatic void build_expected();
      logic [31:0] r [8];
      logic [31:0] w;
      logic [2:0]  rd;
      logic [2:0]  rs;
      exp_addr.delete();
      exp_data.delete();
      for (int i = 0; i < 8; i++) begin
         r[i] = '0;
      end
      for (int i = 0; i < prog_len; i++) begin
         w  = prog[i];
         rd = w[27:25];
         rs = w[24:22];
         case (w[31:28])
            OP_MOVI:  r[rd] = {16'h0, w[15:0]};
            OP_ADD:   r[rd] = r[rd] + r[rs];
            OP_SUB:   r[rd] = r[rd] - r[rs];
            OP_AND:   r[rd] = r[rd] & r[rs];
            OP_OR:    r[rd] = r[rd] | r[rs];
            OP_XOR:   r[rd] = r[rd] ^ r[rs];
            OP_STORE: begin
               exp_addr.push_back({16'h0, w[15:0]});
               exp_data.push_back(r[rd]);
            end
            default: ;   // Unknown codes act as NOP
         endcase
      end
   endfunction

   task automatic add_instr(logic [3:0] op, int rd, int rs, int imm);
      prog[prog_len] = encode(op, rd, rs, imm);
      prog_len++;
   endtask

   task automatic directed_program();
      prog_len = 0;
      add_instr(OP_MOVI, 1, 0, 'h1234);
      add_instr(OP_MOVI, 2, 0, 'h00f0);
      add_instr(OP_STORE, 1, 0, 'h0010);
      add_instr(OP_ADD, 1, 2, 0);
      add_instr(OP_STORE, 1, 0, 'h0011);
      add_instr(OP_SUB, 3, 2, 0);   // Wraps below zero
      add_instr(OP_STORE, 3, 0, 'h0012);
      add_instr(OP_AND, 1, 2, 0);
      add_instr(OP_STORE, 1, 0, 'h0013);
      add_instr(OP_MOVI, 4, 0, 'h5a5a);
      add_instr(OP_OR, 4, 2, 0);
      add_instr(OP_STORE, 4, 0, 'h0014);
      add_instr(OP_XOR, 4, 3, 0);
      add_instr(OP_STORE, 4, 0, 'h0015);
      add_instr(OP_NOP, 0, 0, 0);
      add_instr(OP_MOVI, 5, 0, 'hffff);
      add_instr(OP_STORE, 5, 0, 'hfffe);
      add_instr(OP_STORE, 2, 0, 'h0000);
   endtask

   // Each instruction reads the result of the one before
   task automatic chain_program();
      prog_len = 0;
      add_instr(OP_MOVI, 0, 0, 1);
      for (int k = 0; k < 6; k++) begin
         add_instr(OP_ADD, 0, 0, 0);
         add_instr(OP_STORE, 0, 0, 'h40 + k);
      end
      add_instr(OP_MOVI, 6, 0, 7);
      add_instr(OP_SUB, 6, 0, 0);
      add_instr(OP_XOR, 0, 6, 0);
      add_instr(OP_ADD, 7, 6, 0);
      add_instr(OP_OR, 7, 0, 0);
      add_instr(OP_STORE, 7, 0, 'h50);
      add_instr(OP_STORE, 0, 0, 'h51);
   endtask

   task automatic random_program();
      int         sel;
      logic [3:0] op;
      prog_len = 0;
      for (int i = 0; i < 40; i++) begin
         sel = $random(seed) & 15;
         if (sel >= 12) begin
            op = OP_STORE;
         end else begin
            op = sel[3:0];
         end
         add_instr(op, $random(seed) & 7, $random(seed) & 7, $random(seed) & 'hffff);
      end
   endtask

   task automatic start_reset();
      @(posedge clk);
      reset <= 1'b1;
      @(posedge clk);
   endtask

   task automatic release_and_run(input bit rnd, input int phase, output bit late);
      int cycles;
      random_mode = rnd;
      build_expected();
      repeat (9) @(posedge clk);
      reset  <= 1'b0;
      cycles = 0;
      while (got_count < exp_addr.size() && cycles < RUN_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      late = (got_count < exp_addr.size());
      if (late) begin
         other_errors++;
         $display("Timeout in program %0d: saw %0d of %0d stores", phase, got_count,
                  exp_addr.size());
      end else begin
         repeat (20) @(posedge clk);   // Room for any stray store
      end
   endtask

   // imem model, one request at a time
   always @(posedge clk) begin
      if (reset) begin
         imem_ready    <= 1'b0;
         imem_dp_valid <= 1'b0;
         rsp_busy      <= 1'b0;
         next_fetch    <= '0;
      end else begin
         imem_ready <= random_mode ? (($random(seed) & 3) != 0) : 1'b1;
         if (imem_valid && imem_ready) begin
            assert (imem_address == next_fetch) else begin
               value_errors++;
               $display("[FAIL] t=%0t imem_address expected %h got %h", $time,
                        next_fetch, imem_address);
            end
            next_fetch <= next_fetch + `CPU_INSTR_BYTES;
            rsp_busy   <= 1'b1;
            rsp_word   <= fetch_word(imem_address);
            rsp_wait   <= random_mode ? ($random(seed) & 3) : 0;
         end else if (rsp_busy && !imem_dp_valid) begin
            if (rsp_wait == 0) begin
               imem_dp_valid     <= 1'b1;
               imem_dp_read_data <= rsp_word;
            end else begin
               rsp_wait <= rsp_wait - 1;
            end
         end
         if (imem_dp_valid && imem_dp_ready) begin
            imem_dp_valid <= 1'b0;
            rsp_busy      <= 1'b0;
         end
      end
   end

   // wmem model and store compare
   always @(posedge clk) begin
      if (reset) begin
         wmem_ready <= 1'b0;
         got_count  <= 0;
      end else begin
         // Rare wmem_ready lets later instructions pile up into the scoreboard
         wmem_ready <= random_mode ? (($random(seed) & 7) == 0) : 1'b1;
         if (wmem_valid && wmem_ready) begin
            assert (got_count < exp_addr.size()) else begin
               other_errors++;
               $display("Store to address %h at %0t came after all expected stores",
                        wmem_address, $time);
            end
            if (got_count < exp_addr.size()) begin
               assert (wmem_address == exp_addr[got_count]) else begin
                  value_errors++;
                  $display("[FAIL] t=%0t wmem_address expected %h got %h", $time,
                           exp_addr[got_count], wmem_address);
               end
               assert (wmem_wr_data == exp_data[got_count]) else begin
                  value_errors++;
                  $display("[FAIL] t=%0t wmem_wr_data expected %h got %h", $time,
                           exp_data[got_count], wmem_wr_data);
               end
            end
            got_count <= got_count + 1;
         end
      end
   end

   // Quiet outputs in reset and the cycle after
   always @(posedge clk) begin
      rst_q  <= reset;
      rst_qq <= rst_q;
      if (rst_q && rst_qq) begin
         assert (!imem_valid) else begin
            value_errors++;
            $display("[FAIL] t=%0t imem_valid expected 0 got %b", $time, imem_valid);
         end
         assert (!wmem_valid) else begin
            value_errors++;
            $display("[FAIL] t=%0t wmem_valid expected 0 got %b", $time, wmem_valid);
         end
      end
   end

   initial begin
      for (int phase = 0; phase < 5 && !timed_out; phase++) begin
         start_reset();
         case (phase)
            0, 2:    directed_program();
            1, 3:    chain_program();
            default: random_program();
         endcase
         release_and_run(phase >= 2, phase, timed_out);
      end
      $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
cpu_pkg.sv
pipe_skid_buffer.sv
fetch_unit.sv
decode_unit.sv
register_access.sv
execute_unit.sv
top_pipeline.sv
top_pipeline_checker.sv
tb_top_pipeline.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_top_pipeline \
   -o sim_tb_top_pipeline
./obj_dir/sim_tb_top_pipeline | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
